// File: source/ex_pkg.sv
/*
  Widths, data types and operator encodings shared by the execute stage.
  RTL modules import this package in their bodies and use scoped names in ports.
*/
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////

  // Data path width
  localparam int unsigned xlen = 32;
  // Register file address width
  localparam int unsigned rf_addr_w = 5;
  // Divider iteration counter and leading-zero count of 0..32
  localparam int unsigned div_cnt_w = 6;
  // Full-length division runs one iteration per quotient bit
  localparam int unsigned div_iter_c = 32;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  // Operands, results and program counters
  typedef logic [xlen-1:0] word_t;

  // Destination register address
  typedef logic [rf_addr_w-1:0] rf_addr_t;

  // ALU operators; the last six are the branch comparisons
  typedef enum logic [3:0] {
    alu_add  = 4'h0,
    alu_sub  = 4'h1,
    alu_xor  = 4'h2,
    alu_or   = 4'h3,
    alu_and  = 4'h4,
    alu_sll  = 4'h5,
    alu_srl  = 4'h6,
    alu_sra  = 4'h7,
    alu_slt  = 4'h8,
    alu_sltu = 4'h9,
    alu_eq   = 4'ha,
    alu_ne   = 4'hb,
    alu_lt   = 4'hc,
    alu_ge   = 4'hd,
    alu_ltu  = 4'he,
    alu_geu  = 4'hf
  } alu_op_e;

  // Unsigned divider operators
  typedef enum logic {
    div_divu = 1'b0,
    div_remu = 1'b1
  } div_op_e;

endpackage

// File: source/ex_alu.sv
/*
  Single-cycle ALU of the execute stage.
  One shared 33-bit adder serves add, sub and all comparisons.
  The leading-zero counter is lent to the divider during its setup cycle.
*/
`timescale 1ns/1ps

module ex_alu (
  input  ex_pkg::alu_op_e                operator_i,
  input  ex_pkg::word_t                  operand_a_i,
  input  ex_pkg::word_t                  operand_b_i,
  input  ex_pkg::word_t                  clz_data_i,
  output ex_pkg::word_t                  result_o,
  output logic                           cmp_result_o,
  output logic [ex_pkg::div_cnt_w-1:0]   clz_result_o
);

  import ex_pkg::*;

  // Adder and comparator
  logic            use_sub;
  logic            signed_cmp;
  logic [xlen:0]   adder_a;
  logic [xlen:0]   adder_b;
  logic [xlen:0]   adder_sum;
  logic            is_less;
  logic            is_equal;

  // Shifter
  logic [4:0]      shamt;
  word_t           sra_result;

  // Returns 32 for an all-zero word
  function automatic logic [div_cnt_w-1:0] count_lz(input word_t data);
    logic [div_cnt_w-1:0] cnt;
    cnt = div_cnt_w'(xlen);
    // Highest set bit wins since it is visited last
    for (int i = 0; i < xlen; i++) begin
      if (data[i]) begin
        cnt = div_cnt_w'(xlen - 1 - i);
      end
    end
    return cnt;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Adder
  //////////////////////////////////////////////////////////////////////

  // Only add uses the non-inverted operand
  assign use_sub    = (operator_i != alu_add);
  assign signed_cmp = operator_i inside {alu_slt, alu_lt, alu_ge};

  // Extra top bit is sign or zero extension, so bit xlen is the true sign of a-b
  assign adder_a   = {signed_cmp & operand_a_i[xlen-1], operand_a_i};
  assign adder_b   = {signed_cmp & operand_b_i[xlen-1], operand_b_i};
  assign adder_sum = adder_a + (use_sub ? ~adder_b : adder_b) + {{xlen{1'b0}}, use_sub};

  assign is_less  = adder_sum[xlen];
  assign is_equal = (operand_a_i == operand_b_i);

  //////////////////////////////////////////////////////////////////////
  // Comparison result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (operator_i)
      alu_eq:          cmp_result_o = is_equal;
      alu_ne:          cmp_result_o = !is_equal;
      alu_ge, alu_geu: cmp_result_o = !is_less;
      // slt, sltu, lt, ltu
      default:         cmp_result_o = is_less;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Shifter and result mux
  //////////////////////////////////////////////////////////////////////

  // RV32 uses only the low five bits of the shift amount
  assign shamt      = operand_b_i[4:0];
  assign sra_result = word_t'($signed(operand_a_i) >>> shamt);

  always_comb begin
    unique case (operator_i)
      alu_add, alu_sub: result_o = adder_sum[xlen-1:0];
      alu_xor:          result_o = operand_a_i ^ operand_b_i;
      alu_or:           result_o = operand_a_i | operand_b_i;
      alu_and:          result_o = operand_a_i & operand_b_i;
      alu_sll:          result_o = operand_a_i << shamt;
      alu_srl:          result_o = operand_a_i >> shamt;
      alu_sra:          result_o = sra_result;
      // Compares write a zero-extended flag
      default:          result_o = {{(xlen-1){1'b0}}, cmp_result_o};
    endcase
  end

  // Leading zeros of the divider word
  assign clz_result_o = count_lz(clz_data_i);

endmodule

// File: source/ex_div.sv
/*
  Iterative unsigned divider for DIVU and REMU, one quotient bit per cycle.
  Leading iterations are skipped using the ALU's leading-zero count of the divisor,
  unless data-independent timing asks for all 32 iterations.
*/
`timescale 1ns/1ps

module ex_div (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           valid_i,
  input  logic                           ready_i,
  input  ex_pkg::div_op_e                operator_i,
  input  ex_pkg::word_t                  op_a_i,
  input  ex_pkg::word_t                  op_b_i,
  input  logic                           data_ind_timing_i,
  input  logic [ex_pkg::div_cnt_w-1:0]   clz_result_i,
  output logic                           ready_o,
  output logic                           valid_o,
  output ex_pkg::word_t                  clz_data_o,
  output ex_pkg::word_t                  result_o
);

  import ex_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_setup,
    s_iter,
    s_finish
  } div_state_e;

  div_state_e              state_q;
  div_state_e              state_d;
  logic [div_cnt_w-1:0]    cnt_q;

  // Partial remainder, and dividend bits that turn into quotient bits
  word_t                   rem_q;
  word_t                   quo_q;

  // Setup
  logic                    div_by_zero;
  logic                    short_cut;
  logic [div_cnt_w-1:0]    iter_num;
  logic [div_cnt_w-1:0]    skip_num;
  logic [2*xlen-1:0]       start_word;

  // One restoring step
  logic [xlen:0]           partial;
  logic [xlen+1:0]         trial;
  logic                    sub_ok;

  //////////////////////////////////////////////////////////////////////
  // Setup
  //////////////////////////////////////////////////////////////////////

  // Divisor goes to the ALU counter only while it is needed
  assign clz_data_o  = (state_q == s_setup) ? op_b_i : '0;
  assign div_by_zero = (clz_result_i == div_cnt_w'(div_iter_c));
  assign short_cut   = div_by_zero && !data_ind_timing_i;

  // Quotient has bits only at positions 0..clz, so clz+1 steps suffice
  assign iter_num = data_ind_timing_i ? div_cnt_w'(div_iter_c) : clz_result_i + 1'b1;
  assign skip_num = div_cnt_w'(div_iter_c) - iter_num;

  // Skipped steps only shift dividend bits into the remainder
  assign start_word = {{xlen{1'b0}}, op_a_i} << skip_num;

  //////////////////////////////////////////////////////////////////////
  // Iteration step
  //////////////////////////////////////////////////////////////////////

  assign partial = {rem_q, quo_q[xlen-1]};
  assign trial   = {1'b0, partial} - {2'b00, op_b_i};
  assign sub_ok  = !trial[xlen+1];

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      s_idle:   if (valid_i) state_d = s_setup;
      s_setup:  state_d = short_cut ? s_finish : s_iter;
      s_iter:   if (cnt_q == div_cnt_w'(1)) state_d = s_finish;
      s_finish: if (ready_i) state_d = s_idle;
      default:  state_d = s_idle;
    endcase
    // Kill or halt drops valid and aborts the operation
    if (!valid_i) begin
      state_d = s_idle;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= s_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == s_setup) begin
        cnt_q <= iter_num;
      end else if (state_q == s_iter) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    if (state_q == s_setup) begin
      if (short_cut) begin
        // RISC-V divide by zero
        rem_q <= op_a_i;
        quo_q <= '1;
      end else begin
        rem_q <= start_word[2*xlen-1:xlen];
        quo_q <= start_word[xlen-1:0];
      end
    end else if (state_q == s_iter) begin
      rem_q <= sub_ok ? trial[xlen-1:0] : partial[xlen-1:0];
      quo_q <= {quo_q[xlen-2:0], sub_ok};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign valid_o  = (state_q == s_finish);
  // Free when idle, or when the finished result leaves this cycle
  assign ready_o  = ((state_q == s_idle) && !valid_i) || ((state_q == s_finish) && ready_i);
  assign result_o = (operator_i == div_remu) ? rem_q : quo_q;

endmodule

// File: source/ex_wb_reg.sv
/*
  EX/WB pipeline register.
  Loads on the EX to WB handshake and inserts a bubble when WB is ready but EX is empty.
*/
`timescale 1ns/1ps

module ex_wb_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ex_valid_i,
  input  logic                wb_ready_i,
  input  logic                rf_we_i,
  input  ex_pkg::rf_addr_t    rf_waddr_i,
  input  ex_pkg::word_t       rf_wdata_i,
  input  ex_pkg::word_t       pc_i,
  input  logic                bch_taken_i,
  output logic                wb_instr_valid_o,
  output logic                wb_rf_we_o,
  output ex_pkg::rf_addr_t    wb_rf_waddr_o,
  output ex_pkg::word_t       wb_rf_wdata_o,
  output ex_pkg::word_t       wb_pc_o,
  output logic                wb_bch_taken_o
);

  logic handshake;

  // Item moves from EX to WB
  assign handshake = ex_valid_i && wb_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_instr_valid_o <= 1'b0;
      wb_rf_we_o       <= 1'b0;
      wb_bch_taken_o   <= 1'b0;
    end else if (handshake) begin
      wb_instr_valid_o <= 1'b1;
      wb_rf_we_o       <= rf_we_i;
      wb_bch_taken_o   <= bch_taken_i;
    end else if (wb_ready_i) begin
      // WB takes a bubble
      wb_instr_valid_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (handshake) begin
      wb_pc_o <= pc_i;
      // Write-back fields change only for writing instructions
      if (rf_we_i) begin
        wb_rf_waddr_o <= rf_waddr_i;
        wb_rf_wdata_o <= rf_wdata_i;
      end
    end
  end

endmodule

// File: source/ex_stage.sv
/*
  Execute stage top level. Takes one decoded instruction from ID, computes it in
  the ALU or the divider, resolves branches and registers the result toward WB.
*/
`timescale 1ns/1ps

module ex_stage (
  input  logic                clk,
  input  logic                rst_n,
  // From ID
  input  logic                instr_valid_i,
  input  logic                alu_en_i,
  input  logic                div_en_i,
  input  logic                alu_bch_i,
  input  ex_pkg::alu_op_e     alu_operator_i,
  input  ex_pkg::div_op_e     div_operator_i,
  input  ex_pkg::word_t       operand_a_i,
  input  ex_pkg::word_t       operand_b_i,
  input  ex_pkg::word_t       operand_c_i,
  input  ex_pkg::word_t       pc_i,
  input  ex_pkg::word_t       pc_if_i,
  input  logic                rf_we_i,
  input  ex_pkg::rf_addr_t    rf_waddr_i,
  // From controller
  input  logic                data_ind_timing_i,
  input  logic                kill_ex_i,
  input  logic                halt_ex_i,
  // Stage handshake
  input  logic                wb_ready_i,
  output logic                ex_ready_o,
  output logic                ex_valid_o,
  // To IF
  output logic                branch_decision_o,
  output ex_pkg::word_t       branch_target_o,
  // EX/WB register
  output logic                wb_instr_valid_o,
  output logic                wb_rf_we_o,
  output ex_pkg::rf_addr_t    wb_rf_waddr_o,
  output ex_pkg::word_t       wb_rf_wdata_o,
  output ex_pkg::word_t       wb_pc_o,
  output logic                wb_bch_taken_o
);

  import ex_pkg::*;

  logic                    instr_valid;
  logic                    div_valid;
  logic                    div_ready;
  logic                    div_result_valid;
  word_t                   alu_result;
  logic                    alu_cmp_result;
  word_t                   div_result;
  word_t                   rf_wdata;
  word_t                   clz_data;
  logic [div_cnt_w-1:0]    clz_result;
  logic                    bch_taken;

  // Kill and halt both hide the instruction from the units
  assign instr_valid = instr_valid_i && !kill_ex_i && !halt_ex_i;
  assign div_valid   = div_en_i && instr_valid;

  assign rf_wdata = div_en_i ? div_result : alu_result;

  //////////////////////////////////////////////////////////////////////
  // Branch outcome
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (data_ind_timing_i) begin
      // Always redirect; a not-taken branch redirects to the IF pc
      branch_decision_o = 1'b1;
      branch_target_o   = alu_cmp_result ? operand_c_i : pc_if_i;
    end else begin
      branch_decision_o = alu_cmp_result;
      branch_target_o   = operand_c_i;
    end
  end

  assign bch_taken = alu_bch_i && branch_decision_o;

  // Kill frees the stage at once, halt stalls it
  assign ex_ready_o = kill_ex_i || (wb_ready_i && div_ready && !halt_ex_i);
  // The single-cycle ALU always has its result
  assign ex_valid_o = (alu_en_i || (div_en_i && div_result_valid)) && instr_valid;

  //////////////////////////////////////////////////////////////////////
  // Units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (operand_a_i),
    .operand_b_i  (operand_b_i),
    .clz_data_i   (clz_data),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result),
    .clz_result_o (clz_result)
  );

  ex_div u_div (
    .clk               (clk),
    .rst_n             (rst_n),
    .valid_i           (div_valid),
    .ready_i           (wb_ready_i),
    .operator_i        (div_operator_i),
    .op_a_i            (operand_a_i),
    .op_b_i            (operand_b_i),
    .data_ind_timing_i (data_ind_timing_i),
    .clz_result_i      (clz_result),
    .ready_o           (div_ready),
    .valid_o           (div_result_valid),
    .clz_data_o        (clz_data),
    .result_o          (div_result)
  );

  ex_wb_reg u_wb_reg (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_valid_i       (ex_valid_o),
    .wb_ready_i       (wb_ready_i),
    .rf_we_i          (rf_we_i),
    .rf_waddr_i       (rf_waddr_i),
    .rf_wdata_i       (rf_wdata),
    .pc_i             (pc_i),
    .bch_taken_i      (bch_taken),
    .wb_instr_valid_o (wb_instr_valid_o),
    .wb_rf_we_o       (wb_rf_we_o),
    .wb_rf_waddr_o    (wb_rf_waddr_o),
    .wb_rf_wdata_o    (wb_rf_wdata_o),
    .wb_pc_o          (wb_pc_o),
    .wb_bch_taken_o   (wb_bch_taken_o)
  );

endmodule

// File: tb/ex_stage_properties.sv
/*
  Concurrent assertions on the execute stage outputs.
  The bind at the end of this file attaches them to every ex_stage instance.
*/
`timescale 1ns/1ps

module ex_stage_properties (
  input logic clk,
  input logic rst_n,
  input logic instr_valid_i,
  input logic kill_ex_i,
  input logic halt_ex_i,
  input logic data_ind_timing_i,
  input logic branch_decision_i,
  input logic ex_valid_i,
  input logic wb_ready_i,
  input logic wb_instr_valid_i
);

  int unsigned fail_count = 0;

  // Data-independent timing always redirects fetch
  dit_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    data_ind_timing_i |-> branch_decision_i)
    else begin
      fail_count++;
      $error("branch decision low while data-independent timing is on");
    end

  // No result without a live instruction that neither kill nor halt hides
  valid_gating: assert property (@(posedge clk) disable iff (!rst_n)
    (!instr_valid_i || kill_ex_i || halt_ex_i) |-> !ex_valid_i)
    else begin
      fail_count++;
      $error("ex_valid_o high without a gated valid instruction");
    end

  // WB ready with EX empty inserts a bubble
  bubble_insert: assert property (@(posedge clk) disable iff (!rst_n)
    (wb_ready_i && !ex_valid_i) |=> !wb_instr_valid_i)
    else begin
      fail_count++;
      $error("wb_instr_valid_o still high after a bubble edge");
    end

endmodule

bind ex_stage ex_stage_properties u_props (
  .clk               (clk),
  .rst_n             (rst_n),
  .instr_valid_i     (instr_valid_i),
  .kill_ex_i         (kill_ex_i),
  .halt_ex_i         (halt_ex_i),
  .data_ind_timing_i (data_ind_timing_i),
  .branch_decision_i (branch_decision_o),
  .ex_valid_i        (ex_valid_o),
  .wb_ready_i        (wb_ready_i),
  .wb_instr_valid_i  (wb_instr_valid_o)
);

// File: tb/tb_ex_stage.sv
/*
  Testbench for the execute stage. Vectors come from tb/ex_testdata.txt and are
  issued as ID would issue them, while WB ready drops at random. Every WB item is
  checked in issue order against the expected values in the file.
*/
`timescale 1ns/1ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int    clk_period   = 20;
  localparam int    reset_cycles = 8;
  // Budget per vector covers a full-length divide under back-pressure
  localparam int    vec_cycles   = 40;
  localparam word_t pc_base      = 32'h0000_1000;

  // Vector kinds in the first column
  localparam logic [3:0] kind_bch  = 4'h1;
  localparam logic [3:0] kind_div  = 4'h2;
  localparam logic [3:0] kind_kill = 4'h3;

  logic clk;
  logic rst_n;
  logic instr_valid_i;
  logic alu_en_i;
  logic div_en_i;
  logic alu_bch_i;
  alu_op_e alu_operator_i;
  div_op_e div_operator_i;
  word_t operand_a_i;
  word_t operand_b_i;
  word_t operand_c_i;
  word_t pc_i;
  word_t pc_if_i;
  logic rf_we_i;
  rf_addr_t rf_waddr_i;
  logic data_ind_timing_i;
  logic kill_ex_i;
  logic halt_ex_i;
  logic wb_ready_i;
  logic ex_ready_o;
  logic ex_valid_o;
  logic branch_decision_o;
  word_t branch_target_o;
  logic wb_instr_valid_o;
  logic wb_rf_we_o;
  rf_addr_t wb_rf_waddr_o;
  word_t wb_rf_wdata_o;
  word_t wb_pc_o;
  logic wb_bch_taken_o;

  integer seed = 32'h2c03;
  logic loaded = 1'b0;

  // One vector entry per data line
  logic [3:0] v_kind[$];
  logic [3:0] v_op[$];
  word_t v_a[$];
  word_t v_b[$];
  word_t v_c[$];
  word_t v_pcif[$];
  logic v_dit[$];
  logic v_we[$];
  rf_addr_t v_waddr[$];
  word_t v_res[$];
  logic v_dec[$];
  word_t v_tgt[$];

  // Items expected at WB, oldest first
  logic q_we[$];
  rf_addr_t q_addr[$];
  word_t q_data[$];
  word_t q_pc[$];
  logic q_bch[$];

  // Monitor state for the next clock edge
  logic hs_pending = 1'b0;
  logic bubble_pending = 1'b0;
  logic hold_pending = 1'b0;
  logic held_valid;
  logic held_we;
  rf_addr_t held_addr;
  word_t held_data;
  word_t held_pc;
  logic held_bch;
  // Register file write seen last, which non-writing items must leave in place
  rf_addr_t last_addr;
  word_t last_data;

  ex_stage DUT (.*);

  initial begin : clock
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input rf_addr_t got, input rf_addr_t exp);
    if (got !== exp) fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, exp));
  endtask

  task automatic load_vectors();
    int fd;
    int n;
    string line;
    logic [3:0] f_kind;
    logic [3:0] f_op;
    word_t f_a;
    word_t f_b;
    word_t f_c;
    word_t f_pcif;
    logic f_dit;
    logic f_we;
    rf_addr_t f_waddr;
    word_t f_res;
    logic f_dec;
    word_t f_tgt;
    fd = $fopen("tb/ex_testdata.txt", "r");
    if (fd == 0) fail_run("Could not open the test data file");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip blank and comment lines
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f_kind, f_op, f_a, f_b,
                  f_c, f_pcif, f_dit, f_we, f_waddr, f_res, f_dec, f_tgt);
      if (n != 12) fail_run("A line of the test data file has the wrong number of fields");
      v_kind.push_back(f_kind);
      v_op.push_back(f_op);
      v_a.push_back(f_a);
      v_b.push_back(f_b);
      v_c.push_back(f_c);
      v_pcif.push_back(f_pcif);
      v_dit.push_back(f_dit);
      v_we.push_back(f_we);
      v_waddr.push_back(f_waddr);
      v_res.push_back(f_res);
      v_dec.push_back(f_dec);
      v_tgt.push_back(f_tgt);
    end
    $fclose(fd);
  endtask

  // Presents one instruction and returns on the negedge before the edge that takes it
  task automatic run_vector(input int idx);
    logic is_div;
    is_div = (v_kind[idx] == kind_div) || (v_kind[idx] == kind_kill);
    @(posedge clk);
    instr_valid_i     <= 1'b1;
    kill_ex_i         <= 1'b0;
    alu_en_i          <= !is_div;
    div_en_i          <= is_div;
    alu_bch_i         <= (v_kind[idx] == kind_bch);
    alu_operator_i    <= is_div ? alu_add : alu_op_e'(v_op[idx]);
    div_operator_i    <= div_op_e'(v_op[idx][0]);
    operand_a_i       <= v_a[idx];
    operand_b_i       <= v_b[idx];
    operand_c_i       <= v_c[idx];
    pc_i              <= pc_base + word_t'(idx * 4);
    pc_if_i           <= v_pcif[idx];
    rf_we_i           <= v_we[idx];
    rf_waddr_i        <= v_waddr[idx];
    data_ind_timing_i <= v_dit[idx];
    if (v_kind[idx] == kind_kill) begin
      // Abort the divide a few cycles in; ready must follow kill at once
      repeat (3) @(posedge clk);
      kill_ex_i <= 1'b1;
      @(negedge clk);
      check_bit("ex_ready_o", ex_ready_o, 1'b1);
      check_bit("ex_valid_o", ex_valid_o, 1'b0);
    end else begin
      q_we.push_back(v_we[idx]);
      q_addr.push_back(v_waddr[idx]);
      q_data.push_back(v_res[idx]);
      q_pc.push_back(pc_base + word_t'(idx * 4));
      q_bch.push_back((v_kind[idx] == kind_bch) && v_dec[idx]);
      @(negedge clk);
      // ALU results are valid in the issue cycle
      if (!is_div) check_bit("ex_valid_o", ex_valid_o, 1'b1);
      if (v_kind[idx] == kind_bch) begin
        check_bit("branch_decision_o", branch_decision_o, v_dec[idx]);
        check_word("branch_target_o", branch_target_o, v_tgt[idx]);
      end
      while (!ex_ready_o) @(negedge clk);
    end
  endtask

  // Item loaded into EX/WB on the last edge
  task automatic check_result();
    logic we;
    rf_addr_t exp_addr;
    word_t exp_data;
    if (q_pc.size() == 0) fail_run("WB received an item that was never issued");
    we       = q_we.pop_front();
    exp_addr = q_addr.pop_front();
    exp_data = q_data.pop_front();
    if (we) begin
      last_addr = exp_addr;
      last_data = exp_data;
    end
    check_bit("wb_instr_valid_o", wb_instr_valid_o, 1'b1);
    check_bit("wb_rf_we_o", wb_rf_we_o, we);
    check_addr("wb_rf_waddr_o", wb_rf_waddr_o, last_addr);
    check_word("wb_rf_wdata_o", wb_rf_wdata_o, last_data);
    check_word("wb_pc_o", wb_pc_o, q_pc.pop_front());
    check_bit("wb_bch_taken_o", wb_bch_taken_o, q_bch.pop_front());
  endtask

  //////////////////////////////////////////////////////////////////////
  // WB side
  //////////////////////////////////////////////////////////////////////

  // WB ready about three cycles in four
  always @(posedge clk) begin
    if (rst_n) wb_ready_i <= (($random(seed) & 3) != 0);
  end

  // Classifies each edge from the stable levels before it, then checks after it
  always @(negedge clk) begin
    if (rst_n) begin
      if (hold_pending) begin
        check_bit("wb_instr_valid_o", wb_instr_valid_o, held_valid);
        check_bit("wb_rf_we_o", wb_rf_we_o, held_we);
        check_addr("wb_rf_waddr_o", wb_rf_waddr_o, held_addr);
        check_word("wb_rf_wdata_o", wb_rf_wdata_o, held_data);
        check_word("wb_pc_o", wb_pc_o, held_pc);
        check_bit("wb_bch_taken_o", wb_bch_taken_o, held_bch);
      end
      if (hs_pending) check_result();
      else if (bubble_pending) check_bit("wb_instr_valid_o", wb_instr_valid_o, 1'b0);
      hs_pending     = ex_valid_o && wb_ready_i;
      bubble_pending = !ex_valid_o && wb_ready_i;
      hold_pending   = !wb_ready_i;
      held_valid     = wb_instr_valid_o;
      held_we        = wb_rf_we_o;
      held_addr      = wb_rf_waddr_o;
      held_data      = wb_rf_wdata_o;
      held_pc        = wb_pc_o;
      held_bch       = wb_bch_taken_o;
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat (reset_cycles + v_kind.size() * vec_cycles) @(posedge clk);
    fail_run("Timeout: the stage stopped making progress");
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    rst_n             = 1'b0;
    instr_valid_i     = 1'b0;
    alu_en_i          = 1'b0;
    div_en_i          = 1'b0;
    alu_bch_i         = 1'b0;
    alu_operator_i    = alu_add;
    div_operator_i    = div_divu;
    operand_a_i       = '0;
    operand_b_i       = '0;
    operand_c_i       = '0;
    pc_i              = '0;
    pc_if_i           = '0;
    rf_we_i           = 1'b0;
    rf_waddr_i        = '0;
    data_ind_timing_i = 1'b0;
    kill_ex_i         = 1'b0;
    halt_ex_i         = 1'b0;
    wb_ready_i        = 1'b1;
    load_vectors();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    // Reset state with the divider idle
    @(negedge clk);
    check_bit("wb_instr_valid_o", wb_instr_valid_o, 1'b0);
    check_bit("wb_rf_we_o", wb_rf_we_o, 1'b0);
    check_bit("ex_valid_o", ex_valid_o, 1'b0);
    check_bit("ex_ready_o", ex_ready_o, 1'b1);
    for (int i = 0; i < v_kind.size(); i++) run_vector(i);
    @(posedge clk);
    instr_valid_i <= 1'b0;
    alu_en_i      <= 1'b0;
    div_en_i      <= 1'b0;
    kill_ex_i     <= 1'b0;
    // Drain the last items through WB
    while (q_pc.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    if (DUT.u_props.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("Concurrent assertions on the stage failed during the run");
    end
  end

endmodule

// File: tb/ex_testdata.txt
# kind(0 alu, 1 branch, 2 div, 3 killed div) op a b c pc_if dit we waddr exp_result exp_decision exp_target
# all fields hex; op is the ALU operator for kinds 0 and 1, the divider operator for kinds 2 and 3
0 0 00000005 00000007 00000000 00000000 0 1 01 0000000c 0 00000000
0 0 ffffffff 00000002 00000000 00000000 0 1 02 00000001 0 00000000
0 1 00000010 00000020 00000000 00000000 0 1 03 fffffff0 0 00000000
0 2 f0f0f0f0 ff00ff00 00000000 00000000 0 1 04 0ff00ff0 0 00000000
0 3 12340000 00005678 00000000 00000000 0 1 05 12345678 0 00000000
0 4 ff00ff00 0f0f0f0f 00000000 00000000 0 1 06 0f000f00 0 00000000
0 5 80000001 00000024 00000000 00000000 0 1 07 00000010 0 00000000
0 6 80000000 0000001f 00000000 00000000 0 1 08 00000001 0 00000000
0 7 80000000 00000004 00000000 00000000 0 1 09 f8000000 0 00000000
0 8 ffffffff 00000001 00000000 00000000 0 1 0a 00000001 0 00000000
0 9 ffffffff 00000001 00000000 00000000 0 1 0b 00000000 0 00000000
0 8 00000005 fffffffb 00000000 00000000 0 1 0c 00000000 0 00000000
0 0 00000001 00000001 00000000 00000000 0 0 1f 00000002 0 00000000
1 a 00000042 00000042 00002000 00001100 0 0 00 00000001 1 00002000
1 b 00000001 00000001 00002040 00001104 0 0 00 00000000 0 00002040
1 c fffffff0 00000010 00002080 00001108 0 0 00 00000001 1 00002080
1 d fffffff0 00000010 000020c0 0000110c 0 0 00 00000000 0 000020c0
1 e fffffff0 00000010 00002100 00001110 0 0 00 00000000 0 00002100
1 f fffffff0 00000010 00002140 00001114 0 0 00 00000001 1 00002140
1 a 00000001 00000002 00002180 00001118 1 0 00 00000000 1 00001118
1 e 00000001 00000002 000021c0 0000111c 1 0 00 00000001 1 000021c0
1 d 80000000 00000000 00002200 00001120 1 0 00 00000000 1 00001120
2 0 00000064 00000007 00000000 00000000 0 1 10 0000000e 0 00000000
2 1 00000064 00000007 00000000 00000000 0 1 11 00000002 0 00000000
2 0 ffffffff 00000010 00000000 00000000 1 1 12 0fffffff 0 00000000
2 1 ffffffff 00000010 00000000 00000000 1 1 13 0000000f 0 00000000
2 0 12345678 00000000 00000000 00000000 0 1 14 ffffffff 0 00000000
2 1 12345678 00000000 00000000 00000000 0 1 15 12345678 0 00000000
2 0 0000abcd 00000000 00000000 00000000 1 1 16 ffffffff 0 00000000
2 1 0000abcd 00000000 00000000 00000000 1 1 17 0000abcd 0 00000000
2 0 80000000 00000003 00000000 00000000 0 1 18 2aaaaaaa 0 00000000
2 1 ffffffff 80000000 00000000 00000000 0 1 19 7fffffff 0 00000000
3 0 00001000 00000003 00000000 00000000 1 1 1a 00000555 0 00000000
2 0 00001000 00000003 00000000 00000000 0 1 1a 00000555 0 00000000
2 1 00000005 00000009 00000000 00000000 0 0 1b 00000005 0 00000000
0 0 00000001 0000000f 00000000 00000000 0 1 1c 00000010 0 00000000

// File: list.f
source/ex_pkg.sv
source/ex_alu.sv
source/ex_div.sv
source/ex_wb_reg.sv
source/ex_stage.sv
tb/ex_stage_properties.sv
tb/tb_ex_stage.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  # RTL in compile order
  - source/ex_pkg.sv
  - source/ex_alu.sv
  - source/ex_div.sv
  - source/ex_wb_reg.sv
  - source/ex_stage.sv

  # Testbench and bound assertions
  - target: test
    files:
      - tb/ex_stage_properties.sv
      - tb/tb_ex_stage.sv
